// ==== vlog.f ====
logic/flash_pkg.sv
logic/timing_pkg.sv
logic/flash_strobe_if.sv
logic/op_hold_reg.sv
logic/op_sequencer.sv
logic/flash_pins.sv
logic/flash_ctrl_top.sv
tests/flash_checker.sv
tests/tb_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the flash controller testbench with Verilator and runs it once
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --timescale 1ns/100ps -j 0 \
      -f vlog.f --top-module tb_top -o sim_tb_top; then
   echo "verilator build failed"
   exit 1
fi

if ! sim_out="$(./obj_dir/sim_tb_top)"; then
   echo "$sim_out"
   echo "simulation exited with an error status"
   exit 1
fi
echo "$sim_out"

if echo "$sim_out" | grep -qx "ALL CHECKS PASSED"; then
   exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== tests/tb_top.sv ====
// random traffic into a behavioral NOR part; command writes go to 0x555/0x2AA, outside reads
module tb_top;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int ADDR_W      = flash_pkg::ADDR_W_DEF;
   localparam int DATA_W      = flash_pkg::DATA_W_DEF;
   localparam int NUM_REQ     = 400;
   localparam int CYCLE_LIMIT = NUM_REQ * 40;

   logic                 clk_i;
   logic                 rst_i;
   logic                 req_valid_i;
   logic                 req_ready_o;
   flash_pkg::flash_op_t req_op_i;
   logic [ADDR_W-1:0]    req_addr_i;
   logic [DATA_W-1:0]    req_data_i;
   logic                 resp_valid_o;
   logic                 resp_ready_i;
   flash_pkg::flash_op_t resp_op_o;
   logic [DATA_W-1:0]    resp_data_o;
   logic [ADDR_W-1:0]    flash_addr_o;
   logic [DATA_W-1:0]    flash_dq_o;
   logic                 flash_dq_oe_o;
   logic [DATA_W-1:0]    flash_dq_i;
   logic                 flash_ce_n_o;
   logic                 flash_oe_n_o;
   logic                 flash_we_n_o;
   logic                 flash_rst_n_o;
   logic                 finish_chk;
   int                   resp_count;
   int                   error_count;
   int                   cycle_count;
   logic [15:0]          req_lfsr;
   logic [15:0]          rdy_lfsr;   // separate stream for back-pressure
   logic [31:0]          bits;
   logic [31:0]          rdy_bits;
   logic [DATA_W-1:0]    flash_mem [logic [ADDR_W-1:0]];

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      lfsr_next = {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
   endfunction

   task automatic draw_bits(inout logic [15:0] state, input int n, output logic [31:0] val);
      val = '0;
      for (int i = 0; i < n; i++)
      begin
         val   = {val[30:0], state[0]};
         state = lfsr_next(state);
      end
   endtask

   function automatic flash_pkg::flash_op_t pick_op(input logic [2:0] r);
      case (r)
         3'd0:             pick_op = flash_pkg::OP_RESET;
         3'd1:             pick_op = flash_pkg::OP_CMD_WRITE;
         3'd2, 3'd3, 3'd4: pick_op = flash_pkg::OP_READ;
         default:          pick_op = flash_pkg::OP_PROGRAM;
      endcase
   endfunction

   function automatic logic [DATA_W-1:0] stored_word(input logic [ADDR_W-1:0] a);
      stored_word = flash_mem.exists(a) ? flash_mem[a] : ~a[DATA_W-1:0];
   endfunction

   always #5 clk_i = ~clk_i;

   always @(posedge clk_i)
      cycle_count <= cycle_count + 1;

   // the part latches data on the rising WE edge
   always @(posedge flash_we_n_o)
   begin
      if (rst_i && !flash_ce_n_o)
         flash_mem[flash_addr_o] = flash_dq_o;
   end

   assign flash_dq_i = (!flash_ce_n_o && !flash_oe_n_o) ? stored_word(flash_addr_o) : '0;

   initial
   begin
      clk_i       = 1'b0;
      rst_i       = 1'b0;
      req_valid_i = 1'b0;
      req_op_i    = flash_pkg::OP_RESET;
      req_addr_i  = '0;
      req_data_i  = '0;
      req_lfsr    = 16'd24151;
      repeat (8) @(posedge clk_i);
      #1;
      rst_i = 1'b1;
      for (int n = 0; n < NUM_REQ; n++)
      begin
         draw_bits(req_lfsr, 3, bits);
         if (bits[2])
         begin
            req_valid_i = 1'b0;
            repeat (int'(bits[1:0]) + 1) @(posedge clk_i);
            #1;
         end
         draw_bits(req_lfsr, 3, bits);
         req_op_i = pick_op(bits[2:0]);
         draw_bits(req_lfsr, 4, bits);
         req_addr_i = ADDR_W'(bits[3:0]); // 16 words, so reads hit programmed data
         if (req_op_i == flash_pkg::OP_CMD_WRITE)
            req_addr_i = bits[0] ? ADDR_W'(12'h555) : ADDR_W'(12'h2AA);
         draw_bits(req_lfsr, DATA_W, bits);
         req_data_i  = bits[DATA_W-1:0];
         req_valid_i = 1'b1;
         do
            @(posedge clk_i);
         while (!req_ready_o);
         #1;
      end
      req_valid_i = 1'b0;
   end

   initial
   begin
      resp_ready_i = 1'b0;
      rdy_lfsr     = 16'd24151;
      @(posedge rst_i);
      forever
      begin
         @(posedge clk_i);
         #1;
         draw_bits(rdy_lfsr, 2, rdy_bits);
         resp_ready_i = (rdy_bits[1:0] != 2'b00); // stall about one cycle in four
      end
   end

   initial
   begin
      finish_chk = 1'b0;
      @(negedge clk_i);
      while (resp_count < NUM_REQ && cycle_count < CYCLE_LIMIT)
         @(negedge clk_i);
      if (resp_count < NUM_REQ)
         $display("timeout: only %0d of %0d responses after %0d cycles",
                  resp_count, NUM_REQ, cycle_count);
      finish_chk = 1'b1;
      @(negedge clk_i);
      if (error_count == 0 && resp_count == NUM_REQ)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

   flash_ctrl_top #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) dut0 (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .req_valid_i   (req_valid_i),
      .req_ready_o   (req_ready_o),
      .req_op_i      (req_op_i),
      .req_addr_i    (req_addr_i),
      .req_data_i    (req_data_i),
      .resp_valid_o  (resp_valid_o),
      .resp_ready_i  (resp_ready_i),
      .resp_op_o     (resp_op_o),
      .resp_data_o   (resp_data_o),
      .flash_addr_o  (flash_addr_o),
      .flash_dq_o    (flash_dq_o),
      .flash_dq_oe_o (flash_dq_oe_o),
      .flash_dq_i    (flash_dq_i),
      .flash_ce_n_o  (flash_ce_n_o),
      .flash_oe_n_o  (flash_oe_n_o),
      .flash_we_n_o  (flash_we_n_o),
      .flash_rst_n_o (flash_rst_n_o)
   );

   flash_checker #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) chk0 (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .finish_i      (finish_chk),
      .req_valid_i   (req_valid_i),
      .req_ready_i   (req_ready_o),
      .req_op_i      (req_op_i),
      .req_addr_i    (req_addr_i),
      .req_data_i    (req_data_i),
      .resp_valid_i  (resp_valid_o),
      .resp_ready_i  (resp_ready_i),
      .resp_op_i     (resp_op_o),
      .resp_data_i   (resp_data_o),
      .flash_addr_i  (flash_addr_o),
      .flash_wdata_i (flash_dq_o),
      .flash_dq_oe_i (flash_dq_oe_o),
      .flash_ce_n_i  (flash_ce_n_o),
      .flash_oe_n_i  (flash_oe_n_o),
      .flash_we_n_i  (flash_we_n_o),
      .flash_rst_n_i (flash_rst_n_o),
      .resp_count_o  (resp_count),
      .error_count_o (error_count)
   );

endmodule

// ==== tests/flash_checker.sv ====
// assumes ADDR_W >= DATA_W; unwritten words are expected as the inverted low address bits
module flash_checker #(
   parameter int ADDR_W = 23,
   parameter int DATA_W = 16
)(
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  logic                 finish_i,
   input  logic                 req_valid_i,
   input  logic                 req_ready_i,
   input  flash_pkg::flash_op_t req_op_i,
   input  logic [ADDR_W-1:0]    req_addr_i,
   input  logic [DATA_W-1:0]    req_data_i,
   input  logic                 resp_valid_i,
   input  logic                 resp_ready_i,
   input  flash_pkg::flash_op_t resp_op_i,
   input  logic [DATA_W-1:0]    resp_data_i,
   input  logic [ADDR_W-1:0]    flash_addr_i,
   input  logic [DATA_W-1:0]    flash_wdata_i,
   input  logic                 flash_dq_oe_i,
   input  logic                 flash_ce_n_i,
   input  logic                 flash_oe_n_i,
   input  logic                 flash_we_n_i,
   input  logic                 flash_rst_n_i,
   output int                   resp_count_o,
   output int                   error_count_o
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam int RST_WIDTH = int'(timing_pkg::RST_LOW_LAST) - int'(timing_pkg::RST_LOW_FIRST) + 1;

   flash_pkg::flash_op_t op_q[$];      // ops in flight, request order
   logic [DATA_W-1:0]    rd_exp_q[$];
   logic [ADDR_W-1:0]    wr_addr_q[$];
   logic [DATA_W-1:0]    wr_data_q[$];
   logic [DATA_W-1:0]    mem [logic [ADDR_W-1:0]];
   flash_pkg::flash_op_t exp_op;
   logic [DATA_W-1:0]    exp_data;
   logic [ADDR_W-1:0]    exp_addr;
   int                   req_count;
   int                   wr_pulses;
   int                   rst_reqs;
   int                   rst_pulses;
   int                   rst_low;    // cycles seen with RST# low
   logic                 we_n_q;
   logic                 rst_n_q;
   logic                 done;

   task automatic flag_mismatch(input string msg);
      error_count_o++;
      $display("** Error at %0t ns: %s", $time, msg);
   endtask

   task automatic flag_fault(input string msg);
      error_count_o++;
      $display("at %0t ns: %s", $time, msg);
   endtask

   always @(posedge clk_i or negedge rst_i)
   begin
      if (!rst_i)
      begin
         we_n_q  = 1'b1;
         rst_n_q = 1'b1;
         done    = 1'b0;
      end
      else
      begin
         if (req_valid_i && req_ready_i)
         begin
            req_count++;
            op_q.push_back(req_op_i);
            case (req_op_i)
               flash_pkg::OP_READ:
                  rd_exp_q.push_back(mem.exists(req_addr_i) ? mem[req_addr_i]
                                                            : ~req_addr_i[DATA_W-1:0]);
               flash_pkg::OP_PROGRAM:
               begin
                  mem[req_addr_i] = req_data_i;
                  wr_addr_q.push_back(req_addr_i);
                  wr_data_q.push_back(req_data_i);
               end
               flash_pkg::OP_CMD_WRITE:
               begin
                  wr_addr_q.push_back(req_addr_i);
                  wr_data_q.push_back(req_data_i);
               end
               default:
                  rst_reqs++;
            endcase
         end
         if (resp_valid_i && resp_ready_i)
         begin
            resp_count_o++;
            if (op_q.size() == 0)
               flag_fault("a response arrived while no request was outstanding");
            else
            begin
               exp_op = op_q.pop_front();
               if (exp_op == flash_pkg::OP_READ)
                  exp_data = rd_exp_q.pop_front();
               if (resp_op_i != exp_op)
                  flag_mismatch($sformatf("response %0d has op %s, expected %s",
                                          resp_count_o, resp_op_i.name(), exp_op.name()));
               else if (exp_op == flash_pkg::OP_READ && resp_data_i !== exp_data)
                  flag_mismatch($sformatf("read response %0d data %h, expected %h",
                                          resp_count_o, resp_data_i, exp_data));
            end
         end
         // WE just went high, bus still holds the write
         if (!we_n_q && flash_we_n_i)
         begin
            wr_pulses++;
            if (wr_addr_q.size() == 0)
               flag_fault("a WE pulse occurred with no write request pending");
            else
            begin
               exp_addr = wr_addr_q.pop_front();
               exp_data = wr_data_q.pop_front();
               if (flash_addr_i !== exp_addr || flash_wdata_i !== exp_data || !flash_dq_oe_i)
                  flag_mismatch($sformatf("WE rise addr %h data %h oe %b, expected %h %h",
                                          flash_addr_i, flash_wdata_i, flash_dq_oe_i,
                                          exp_addr, exp_data));
            end
         end
         if (!flash_rst_n_i)
         begin
            rst_low++;
            if (!flash_ce_n_i || !flash_oe_n_i || !flash_we_n_i)
               flag_mismatch("CE, OE or WE low during the reset pulse");
         end
         else if (!rst_n_q)
         begin
            rst_pulses++;
            if (rst_low != RST_WIDTH)
               flag_mismatch($sformatf("reset pulse %0d cycles, expected %0d",
                                       rst_low, RST_WIDTH));
            rst_low = 0;
         end
         if (!flash_we_n_i && !flash_oe_n_i)
            flag_mismatch("WE and OE low together");
         if (flash_dq_oe_i && (flash_ce_n_i || !flash_oe_n_i))
            flag_mismatch("data bus driven without CE low and OE high");
         we_n_q  = flash_we_n_i;
         rst_n_q = flash_rst_n_i;
         if (finish_i && !done)
         begin
            done = 1'b1;
            if (op_q.size() != 0)
               flag_fault($sformatf("%0d requests never got a response", op_q.size()));
            if (wr_addr_q.size() != 0)
               flag_fault($sformatf("%0d writes never produced a WE pulse", wr_addr_q.size()));
            if (rst_pulses != rst_reqs)
               flag_fault($sformatf("%0d reset pulses seen for %0d reset requests",
                                    rst_pulses, rst_reqs));
            $display("requests %0d, responses %0d, write pulses %0d, reset pulses %0d, errors %0d",
                     req_count, resp_count_o, wr_pulses, rst_pulses, error_count_o);
         end
      end
   end

endmodule

// ==== logic/flash_ctrl_top.sv ====
// word-mode NOR timing controller; ready/busy pin not monitored, caller polls status by reads
module flash_ctrl_top #(
   parameter int ADDR_W = flash_pkg::ADDR_W_DEF,
   parameter int DATA_W = flash_pkg::DATA_W_DEF
)(
   input  logic                 clk_i,
   input  logic                 rst_i,

   input  logic                 req_valid_i,
   output logic                 req_ready_o,
   input  flash_pkg::flash_op_t req_op_i,
   input  logic [ADDR_W-1:0]    req_addr_i,
   input  logic [DATA_W-1:0]    req_data_i,

   output logic                 resp_valid_o,
   input  logic                 resp_ready_i,
   output flash_pkg::flash_op_t resp_op_o,
   output logic [DATA_W-1:0]    resp_data_o,

   output logic [ADDR_W-1:0]    flash_addr_o,
   output logic [DATA_W-1:0]    flash_dq_o,
   output logic                 flash_dq_oe_o,
   input  logic [DATA_W-1:0]    flash_dq_i,
   output logic                 flash_ce_n_o,
   output logic                 flash_oe_n_o,
   output logic                 flash_we_n_o,
   output logic                 flash_rst_n_o
);

   typedef struct packed {
      flash_pkg::flash_op_t op;
      logic [ADDR_W-1:0]    addr;
      logic [DATA_W-1:0]    data;
   } req_t;

   typedef struct packed {
      flash_pkg::flash_op_t op;
      logic [DATA_W-1:0]    data;
   } resp_t;

   req_t              req_in;
   req_t              req_q;
   resp_t             resp_d;
   resp_t             resp_out;
   logic              seq_req_valid;
   logic              seq_req_ready;
   logic              seq_resp_valid;
   logic              seq_resp_ready;
   logic [DATA_W-1:0] rd_data;

   flash_strobe_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) strobe0 ();

   assign req_in.op   = req_op_i;
   assign req_in.addr = req_addr_i;
   assign req_in.data = req_data_i;
   assign resp_op_o   = resp_out.op;
   assign resp_data_o = resp_out.data;

   op_hold_reg #(.payload_t(req_t)) req_hold0 (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .in_valid_i  (req_valid_i),
      .in_ready_o  (req_ready_o),
      .in_data_i   (req_in),
      .out_valid_o (seq_req_valid),
      .out_ready_i (seq_req_ready),
      .out_data_o  (req_q)
   );

   op_sequencer #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) seq0 (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .req_valid_i  (seq_req_valid),
      .req_ready_o  (seq_req_ready),
      .req_op_i     (req_q.op),
      .req_addr_i   (req_q.addr),
      .req_data_i   (req_q.data),
      .rd_data_i    (rd_data),
      .resp_valid_o (seq_resp_valid),
      .resp_ready_i (seq_resp_ready),
      .resp_op_o    (resp_d.op),
      .resp_data_o  (resp_d.data),
      .strobe       (strobe0.seq)
   );

   flash_pins #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) pins0 (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .strobe        (strobe0.pins),
      .flash_dq_i    (flash_dq_i),
      .rd_data_o     (rd_data),
      .flash_addr_o  (flash_addr_o),
      .flash_dq_o    (flash_dq_o),
      .flash_dq_oe_o (flash_dq_oe_o),
      .flash_ce_n_o  (flash_ce_n_o),
      .flash_oe_n_o  (flash_oe_n_o),
      .flash_we_n_o  (flash_we_n_o),
      .flash_rst_n_o (flash_rst_n_o)
   );

   op_hold_reg #(.payload_t(resp_t)) resp_hold0 (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .in_valid_i  (seq_resp_valid),
      .in_ready_o  (seq_resp_ready),
      .in_data_i   (resp_d),
      .out_valid_o (resp_valid_o),
      .out_ready_i (resp_ready_i),
      .out_data_o  (resp_out)
   );

endmodule

// ==== logic/flash_pins.sv ====
// pin register stage; every output is a flop, so commands reach the pins one clock late
module flash_pins #(
   parameter int ADDR_W = 23,
   parameter int DATA_W = 16
)(
   input  logic              clk_i,
   input  logic              rst_i,

   flash_strobe_if.pins      strobe,

   input  logic [DATA_W-1:0] flash_dq_i,
   output logic [DATA_W-1:0] rd_data_o,

   output logic [ADDR_W-1:0] flash_addr_o,
   output logic [DATA_W-1:0] flash_dq_o,
   output logic              flash_dq_oe_o,
   output logic              flash_ce_n_o,
   output logic              flash_oe_n_o,
   output logic              flash_we_n_o,
   output logic              flash_rst_n_o
);

   // strobes, inactive (high) out of reset
   always_ff @(posedge clk_i or negedge rst_i)
   begin
      if (!rst_i)
      begin
         flash_ce_n_o  <= 1'b1;
         flash_oe_n_o  <= 1'b1;
         flash_we_n_o  <= 1'b1;
         flash_rst_n_o <= 1'b1;
         flash_dq_oe_o <= 1'b0;
      end
      else
      begin
         flash_ce_n_o  <= !strobe.ce_on;
         flash_oe_n_o  <= !strobe.oe_on;
         flash_we_n_o  <= !strobe.we_on;
         flash_rst_n_o <= !strobe.rst_on;
         flash_dq_oe_o <= strobe.dq_drive;
      end
   end

   // address and write data held for the whole bus cycle
   always_ff @(posedge clk_i)
   begin
      if (strobe.addr_load)
      begin
         flash_addr_o <= strobe.addr;
         flash_dq_o   <= strobe.data;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (strobe.capture)
      begin
         rd_data_o <= flash_dq_i; // OE low for two cycles by now
      end
   end

   a_strobe_under_ce: assert property (@(posedge clk_i) disable iff (!rst_i)
      (!flash_we_n_o || !flash_oe_n_o) |-> !flash_ce_n_o);

endmodule

// ==== logic/op_sequencer.sv ====
// one operation at a time; no new request is taken until the response is handed off
module op_sequencer #(
   parameter int ADDR_W = 23,
   parameter int DATA_W = 16
)(
   input  logic                 clk_i,
   input  logic                 rst_i,

   input  logic                 req_valid_i,
   output logic                 req_ready_o,
   input  flash_pkg::flash_op_t req_op_i,
   input  logic [ADDR_W-1:0]    req_addr_i,
   input  logic [DATA_W-1:0]    req_data_i,

   input  logic [DATA_W-1:0]    rd_data_i,

   output logic                 resp_valid_o,
   input  logic                 resp_ready_i,
   output flash_pkg::flash_op_t resp_op_o,
   output logic [DATA_W-1:0]    resp_data_o,

   flash_strobe_if.seq          strobe
);

   typedef enum logic [1:0] {S_IDLE, S_BUSY, S_RESP} state_t;

   state_t               state;
   timing_pkg::step_t    step;
   timing_pkg::step_t    done_step;
   flash_pkg::flash_op_t cur_op;
   logic [ADDR_W-1:0]    cur_addr;
   logic [DATA_W-1:0]    cur_data;

   assign req_ready_o  = (state == S_IDLE);
   assign resp_valid_o = (state == S_RESP);
   assign resp_op_o    = cur_op;
   assign resp_data_o  = (cur_op == flash_pkg::OP_READ) ? rd_data_i : '0;

   assign strobe.addr = cur_addr;
   assign strobe.data = cur_data;

   always_comb
   begin
      case (cur_op)
         flash_pkg::OP_RESET:   done_step = timing_pkg::RST_DONE;
         flash_pkg::OP_READ:    done_step = timing_pkg::RD_DONE;
         flash_pkg::OP_PROGRAM: done_step = timing_pkg::PG_DONE;
         default:               done_step = timing_pkg::CW_DONE;
      endcase
   end

   // strobe levels from the current step, all idle outside S_BUSY
   always_comb
   begin
      strobe.ce_on     = 1'b0;
      strobe.oe_on     = 1'b0;
      strobe.we_on     = 1'b0;
      strobe.rst_on    = 1'b0;
      strobe.addr_load = 1'b0;
      strobe.dq_drive  = 1'b0;
      strobe.capture   = 1'b0;
      if (state == S_BUSY)
      begin
         case (cur_op)
            flash_pkg::OP_RESET:
            begin
               strobe.rst_on = (step >= timing_pkg::RST_LOW_FIRST) &&
                               (step <= timing_pkg::RST_LOW_LAST);
            end
            flash_pkg::OP_READ:
            begin
               strobe.addr_load = (step == timing_pkg::RD_CE_ON);
               strobe.ce_on     = (step >= timing_pkg::RD_CE_ON) && (step < timing_pkg::RD_CE_OFF);
               strobe.oe_on     = (step >= timing_pkg::RD_OE_ON) && (step < timing_pkg::RD_OE_OFF);
               strobe.capture   = (step == timing_pkg::RD_CAPTURE);
            end
            flash_pkg::OP_PROGRAM:
            begin
               strobe.addr_load = (step == timing_pkg::PG_ADDR);
               strobe.ce_on     = (step >= timing_pkg::PG_CE_ON) && (step < timing_pkg::PG_CE_OFF);
               strobe.we_on     = (step >= timing_pkg::PG_WE_ON) && (step < timing_pkg::PG_WE_OFF);
               strobe.dq_drive  = (step >= timing_pkg::PG_DQ_ON) && (step < timing_pkg::PG_CE_OFF);
            end
            default:
            begin
               strobe.addr_load = (step == timing_pkg::CW_CE_ON);
               strobe.ce_on     = (step >= timing_pkg::CW_CE_ON) && (step < timing_pkg::CW_CE_OFF);
               strobe.we_on     = (step >= timing_pkg::CW_WE_ON) && (step < timing_pkg::CW_WE_OFF);
               strobe.dq_drive  = (step >= timing_pkg::CW_WE_ON) && (step < timing_pkg::CW_CE_OFF);
            end
         endcase
      end
   end

   always_ff @(posedge clk_i or negedge rst_i)
   begin
      if (!rst_i)
      begin
         state  <= S_IDLE;
         step   <= '0;
         cur_op <= flash_pkg::OP_RESET;
      end
      else
      begin
         case (state)
            S_IDLE:
            begin
               if (req_valid_i)
               begin
                  state  <= S_BUSY;
                  step   <= '0; // accept edge is step 0
                  cur_op <= req_op_i;
               end
            end
            S_BUSY:
            begin
               if (step == done_step)
                  state <= S_RESP;
               else
                  step <= step + 1'b1;
            end
            default:
            begin
               if (resp_ready_i)
                  state <= S_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (req_valid_i && req_ready_o)
      begin
         cur_addr <= req_addr_i;
         cur_data <= req_data_i;
      end
   end

   // ready returns only after the response was handed off
   a_no_accept_busy: assert property (@(posedge clk_i) disable iff (!rst_i)
      $rose(req_ready_o) |-> $past(resp_valid_o && resp_ready_i));

   a_no_we_oe: assert property (@(posedge clk_i) disable iff (!rst_i)
      !(strobe.we_on && strobe.oe_on));

endmodule

// ==== logic/op_hold_reg.sv ====
// one-entry buffer, no bypass; full throughput only when the sink drains every cycle
module op_hold_reg #(
   parameter type payload_t = logic
)(
   input  logic     clk_i,
   input  logic     rst_i,

   input  logic     in_valid_i,
   output logic     in_ready_o,
   input  payload_t in_data_i,

   output logic     out_valid_o,
   input  logic     out_ready_i,
   output payload_t out_data_o
);

   logic     full;
   payload_t data_q;

   assign in_ready_o  = !full || out_ready_i; // empty, or emptying this cycle
   assign out_valid_o = full;
   assign out_data_o  = data_q;

   always_ff @(posedge clk_i or negedge rst_i)
   begin
      if (!rst_i)
      begin
         full <= 1'b0;
      end
      else if (in_valid_i && in_ready_o)
      begin
         full <= 1'b1;
      end
      else if (out_ready_i)
      begin
         full <= 1'b0;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (in_valid_i && in_ready_o)
      begin
         data_q <= in_data_i;
      end
   end

   // a stalled item must not change under the consumer
   a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_i)
      out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o));

endmodule

// ==== logic/flash_strobe_if.sv ====
// per-cycle pin commands; levels apply to the pins one clock after they are set
interface flash_strobe_if #(
   parameter int ADDR_W = 23,
   parameter int DATA_W = 16
);

   logic              ce_on;     // chip enable wanted next cycle
   logic              oe_on;
   logic              we_on;
   logic              rst_on;    // device reset held low
   logic              addr_load; // take addr into the address register
   logic              dq_drive;  // drive data onto the bus
   logic              capture;   // sample the bus into read data
   logic [ADDR_W-1:0] addr;
   logic [DATA_W-1:0] data;

   modport seq (
      output ce_on, oe_on, we_on, rst_on, addr_load, dq_drive, capture, addr, data
   );

   modport pins (
      input ce_on, oe_on, we_on, rst_on, addr_load, dq_drive, capture, addr, data
   );

endinterface

// ==== logic/timing_pkg.sv ====
// schedule steps counted in clock cycles from request accept; must stay below 32
package timing_pkg;

   typedef logic [4:0] step_t;

   // device reset pulse
   localparam step_t RST_LOW_FIRST = 5'd3;
   localparam step_t RST_LOW_LAST  = 5'd13;
   localparam step_t RST_DONE      = 5'd20;

   // word read
   localparam step_t RD_CE_ON   = 5'd3;
   localparam step_t RD_OE_ON   = 5'd8;
   localparam step_t RD_CAPTURE = 5'd10; // data valid after OE access time
   localparam step_t RD_OE_OFF  = 5'd12;
   localparam step_t RD_CE_OFF  = 5'd12;
   localparam step_t RD_DONE    = 5'd14;

   // word program
   localparam step_t PG_ADDR   = 5'd5;
   localparam step_t PG_CE_ON  = 5'd6;
   localparam step_t PG_WE_ON  = 5'd7;
   localparam step_t PG_DQ_ON  = 5'd8;
   localparam step_t PG_WE_OFF = 5'd13;
   localparam step_t PG_CE_OFF = 5'd14;
   localparam step_t PG_DONE   = 5'd15;

   // single command write cycle
   localparam step_t CW_CE_ON  = 5'd3;
   localparam step_t CW_WE_ON  = 5'd6;
   localparam step_t CW_WE_OFF = 5'd10;
   localparam step_t CW_CE_OFF = 5'd11;
   localparam step_t CW_DONE   = 5'd11;

endpackage

// ==== logic/flash_pkg.sv ====
// operation codes and default bus widths, sized for a 16-bit parallel NOR part
package flash_pkg;

   // requested operation, one per transfer on the request port
   typedef enum logic [1:0]
   {
      OP_RESET     = 2'd0, // RST# low pulse, no bus cycle
      OP_READ      = 2'd1, // single word read
      OP_PROGRAM   = 2'd2, // word program, caller sends the unlock cycles
      OP_CMD_WRITE = 2'd3  // one bus write, erase and suspend/resume commands
   } flash_op_t;

   // word address bus of the device
   localparam int ADDR_W_DEF = 23;

   // data bus, word mode only
   localparam int DATA_W_DEF = 16;

endpackage
